/* logic/cpuPkg.sv */
/*
 * cpuPkg
 * Shared types for the 16-bit five-stage pipeline: data words, register
 * numbers, opcodes, ALU functions and the instruction field positions.
 */
package cpuPkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  regAddr_t;

    // Major opcode in bits 15..11, all other codes are illegal
    typedef enum logic [4:0] {
        OP_HALT = 5'b00000,
        OP_NOP  = 5'b00001,
        OP_J    = 5'b00100,
        OP_ADDI = 5'b01000,
        OP_BEQZ = 5'b01100,
        OP_ST   = 5'b10000,
        OP_LD   = 5'b10001,
        OP_ALU  = 5'b11011
    } opcode_t;

    // Function field of register instructions
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_XOR = 2'b11
    } aluOp_t;

    // Field positions
    localparam int OPC_MSB   = 15;
    localparam int OPC_LSB   = 11;
    localparam int RS_MSB    = 10;
    localparam int RS_LSB    = 8;
    localparam int RT_MSB    = 7;
    localparam int RT_LSB    = 5;
    localparam int RD_MSB    = 4;
    localparam int RD_LSB    = 2;
    localparam int ALUOP_MSB = 1;
    localparam int ALUOP_LSB = 0;

    // Immediate widths, all sign extended
    localparam int IMM5_W  = 5;
    localparam int IMM8_W  = 8;
    localparam int IMM11_W = 11;

endpackage

/* logic/pipeBus.sv */
/*
 * Pipeline register buses
 * One interface per pipeline register. The stage that holds the register
 * drives it through src, the following stage reads it through dst.
 */
`timescale 1ns/1ps

interface ifIdBus import cpuPkg::*; ();
    logic  valid;
    word_t pc;
    word_t instr;

    modport src (output valid, pc, instr);
    modport dst (input valid, pc, instr);
endinterface

interface idExBus import cpuPkg::*; ();
    logic     valid;
    word_t    nextPc;
    word_t    opA;
    word_t    opB;
    word_t    stData;
    word_t    imm;
    opcode_t  opcode;
    aluOp_t   aluOp;
    regAddr_t dest;
    logic     regWr;
    logic     fault;

    modport src (output valid, nextPc, opA, opB, stData, imm, opcode, aluOp, dest, regWr, fault);
    modport dst (input valid, nextPc, opA, opB, stData, imm, opcode, aluOp, dest, regWr, fault);
endinterface

interface exMemBus import cpuPkg::*; ();
    logic     valid;
    word_t    pc;
    word_t    result;
    word_t    stData;
    opcode_t  opcode;
    regAddr_t dest;
    logic     regWr;
    logic     fault;

    modport src (output valid, pc, result, stData, opcode, dest, regWr, fault);
    modport dst (input valid, pc, result, stData, opcode, dest, regWr, fault);
    // Hazard view for decode
    modport monitor (input valid, dest, regWr);
endinterface

interface memWbBus import cpuPkg::*; ();
    logic     valid;
    word_t    pc;
    word_t    wrValue;
    regAddr_t dest;
    logic     regWr;
    logic     store;
    logic     fault;

    modport src (output valid, pc, wrValue, dest, regWr, store, fault);
    modport dst (input valid, pc, wrValue, dest, regWr, store, fault);
endinterface

/* logic/fetchStage.sv */
/*
 * fetchStage
 * Program counter, instruction memory with its load port, and the IF/ID
 * register. Handles redirect, stall and the latched freeze.
 */
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; #(
    parameter int imemWords = 256
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  progWrEn,
    input  word_t progAddr,
    input  word_t progData,
    input  logic  stall,
    input  logic  redirect,
    input  word_t target,
    input  logic  freeze,
    ifIdBus.src   ifId
);
    localparam int IDX_W = $clog2(imemWords);

    word_t imem [imemWords];
    word_t pc;
    logic  frozen;
    logic  fetchOn;

    // No new fetches once a HALT or a fault has reached execute
    assign fetchOn = !frozen && !freeze;

    always_ff @(posedge clk) begin
        if (progWrEn) begin
            imem[progAddr[IDX_W-1:0]] <= progData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc         <= '0;
            frozen     <= 1'b0;
            ifId.valid <= 1'b0;
        end else begin
            frozen <= frozen || freeze;
            if (redirect) begin
                pc         <= target;
                ifId.valid <= 1'b0;
            end else if (!stall) begin
                if (fetchOn) begin
                    pc         <= pc + word_t'(1);
                    ifId.valid <= 1'b1;
                end else begin
                    ifId.valid <= 1'b0;
                end
            end
        end
    end

    // IF/ID payload, held while decode stalls
    always_ff @(posedge clk) begin
        if (!stall) begin
            ifId.pc    <= pc;
            ifId.instr <= imem[pc[IDX_W-1:0]];
        end
    end

endmodule

/* logic/decodeStage.sv */
/*
 * decodeStage
 * Register file with write-through, instruction decode and immediate
 * extension, the read-after-write stall and the ID/EX register.
 */
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    ifIdBus.dst      ifId,
    idExBus.src      idEx,
    exMemBus.monitor exMemMon,
    memWbBus.dst     memWb,
    input  logic     redirect,
    output logic     stall
);
    word_t    regs [8];
    word_t    instr;
    opcode_t  op;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    regAddr_t dest;
    word_t    rsVal;
    word_t    rtVal;
    word_t    imm;
    logic     wbWr;
    logic     legal;
    logic     usesRs;
    logic     usesRt;
    logic     regWr;
    logic     rsHazard;
    logic     rtHazard;

    assign instr = ifId.instr;
    assign op    = opcode_t'(instr[OPC_MSB:OPC_LSB]);
    assign rs    = instr[RS_MSB:RS_LSB];
    assign rt    = instr[RT_MSB:RT_LSB];
    assign rd    = instr[RD_MSB:RD_LSB];

    // Writeback port, faulty instructions never write
    assign wbWr = memWb.valid && memWb.regWr && !memWb.fault;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWr) begin
            regs[memWb.dest] <= memWb.wrValue;
        end
    end

    // Same-cycle write is visible to the read
    assign rsVal = (wbWr && memWb.dest == rs) ? memWb.wrValue : regs[rs];
    assign rtVal = (wbWr && memWb.dest == rt) ? memWb.wrValue : regs[rt];

    always_comb begin
        legal  = 1'b1;
        usesRs = 1'b0;
        usesRt = 1'b0;
        regWr  = 1'b0;
        dest   = rt;
        imm    = {{(16-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};
        case (op)
            OP_ALU: begin
                usesRs = 1'b1;
                usesRt = 1'b1;
                regWr  = 1'b1;
                dest   = rd;
            end
            OP_ADDI, OP_LD: begin
                usesRs = 1'b1;
                regWr  = 1'b1;
            end
            OP_ST: begin
                usesRs = 1'b1;
                usesRt = 1'b1;
            end
            OP_BEQZ: begin
                usesRs = 1'b1;
                imm    = {{(16-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
            end
            OP_J:    imm = {{(16-IMM11_W){instr[IMM11_W-1]}}, instr[IMM11_W-1:0]};
            OP_HALT, OP_NOP: legal = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    // Producers still in EX or MEM; the WB one is covered by write-through
    assign rsHazard = (idEx.valid && idEx.regWr && idEx.dest == rs)
                   || (exMemMon.valid && exMemMon.regWr && exMemMon.dest == rs);
    assign rtHazard = (idEx.valid && idEx.regWr && idEx.dest == rt)
                   || (exMemMon.valid && exMemMon.regWr && exMemMon.dest == rt);
    assign stall = ifId.valid && ((usesRs && rsHazard) || (usesRt && rtHazard));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid <= ifId.valid && !stall && !redirect;
        end
    end

    // Payload only matters when valid is set
    always_ff @(posedge clk) begin
        idEx.nextPc <= ifId.pc + word_t'(1);
        idEx.opA    <= rsVal;
        idEx.opB    <= rtVal;
        idEx.stData <= rtVal;
        idEx.imm    <= imm;
        idEx.opcode <= op;
        idEx.aluOp  <= aluOp_t'(instr[ALUOP_MSB:ALUOP_LSB]);
        idEx.dest   <= dest;
        idEx.regWr  <= regWr && legal;
        idEx.fault  <= !legal;
    end

endmodule

/* logic/executeStage.sv */
/*
 * executeStage
 * ALU and address adder, branch and jump resolution, the fetch freeze
 * request and the EX/MEM register.
 */
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    idExBus.dst   idEx,
    exMemBus.src  exMem,
    output logic  redirect,
    output word_t target,
    output logic  freeze
);
    word_t aluRes;
    word_t result;
    logic  live;

    // A faulty instruction neither branches nor computes anything useful
    assign live = idEx.valid && !idEx.fault;

    always_comb begin
        case (idEx.aluOp)
            ALU_ADD: aluRes = idEx.opA + idEx.opB;
            ALU_SUB: aluRes = idEx.opA - idEx.opB;
            ALU_AND: aluRes = idEx.opA & idEx.opB;
            default: aluRes = idEx.opA ^ idEx.opB;
        endcase
    end

    // ADDI and the LD/ST address share the adder
    assign result = (idEx.opcode == OP_ALU) ? aluRes : idEx.opA + idEx.imm;

    // Not-taken prediction, so only a taken branch redirects
    always_comb begin
        redirect = 1'b0;
        if (live) begin
            if (idEx.opcode == OP_J) begin
                redirect = 1'b1;
            end else if (idEx.opcode == OP_BEQZ && idEx.opA == '0) begin
                redirect = 1'b1;
            end
        end
    end

    assign target = idEx.nextPc + idEx.imm;
    assign freeze = idEx.valid && (idEx.opcode == OP_HALT || idEx.fault);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid <= idEx.valid;
        end
    end

    always_ff @(posedge clk) begin
        exMem.pc     <= idEx.nextPc - word_t'(1);
        exMem.result <= result;
        exMem.stData <= idEx.stData;
        exMem.opcode <= idEx.opcode;
        exMem.dest   <= idEx.dest;
        exMem.regWr  <= idEx.regWr;
        exMem.fault  <= idEx.fault;
    end

endmodule

/* logic/memoryStage.sv */
/*
 * memoryStage
 * Data memory with range check, writeback value select, the MEM/WB
 * register feeding the retire port, and the sticky halted and err flags.
 */
`timescale 1ns/1ps

module memoryStage import cpuPkg::*; #(
    parameter int dmemWords = 64
) (
    input  logic     clk,
    input  logic     rstN,
    exMemBus.dst     exMem,
    memWbBus.src     memWb,
    output logic     retireValid,
    output word_t    retirePc,
    output logic     retireRegWr,
    output regAddr_t retireReg,
    output word_t    retireData,
    output logic     halted,
    output logic     err
);
    localparam int    IDX_W = $clog2(dmemWords);
    localparam word_t LIMIT = word_t'(dmemWords);

    word_t dmem [dmemWords];
    word_t rdData;
    logic  isLd;
    logic  isSt;
    logic  fault;
    logic  fin;

    assign isLd  = exMem.opcode == OP_LD;
    assign isSt  = exMem.opcode == OP_ST;
    assign fault = exMem.fault || ((isLd || isSt) && exMem.result >= LIMIT);

    // Anything behind a retired HALT or fault is dropped here
    assign fin = exMem.valid && !halted;

    always_ff @(posedge clk) begin
        if (fin && isSt && !fault) begin
            dmem[exMem.result[IDX_W-1:0]] <= exMem.stData;
        end
    end

    assign rdData = dmem[exMem.result[IDX_W-1:0]];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb.valid <= 1'b0;
            halted      <= 1'b0;
            err         <= 1'b0;
        end else begin
            memWb.valid <= fin;
            if (fin && (exMem.opcode == OP_HALT || fault)) begin
                halted <= 1'b1;
            end
            if (fin && fault) begin
                err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        memWb.pc      <= exMem.pc;
        memWb.wrValue <= isLd ? rdData : (isSt ? exMem.stData : exMem.result);
        memWb.dest    <= exMem.dest;
        memWb.regWr   <= exMem.regWr;
        memWb.store   <= isSt;
        memWb.fault   <= fault;
    end

    assign retireValid = memWb.valid;
    assign retirePc    = memWb.pc;
    assign retireRegWr = memWb.valid && memWb.regWr && !memWb.store && !memWb.fault;
    assign retireReg   = memWb.dest;
    assign retireData  = memWb.wrValue;

endmodule

/* logic/procTop.sv */
/*
 * procTop
 * Five-stage pipelined 16-bit processor with a program load port and
 * a retire port for observing completed instructions.
 */
`timescale 1ns/1ps

module procTop import cpuPkg::*; #(
    parameter int imemWords = 256,
    parameter int dmemWords = 64
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     progWrEn,
    input  word_t    progAddr,
    input  word_t    progData,
    output logic     retireValid,
    output word_t    retirePc,
    output logic     retireRegWr,
    output regAddr_t retireReg,
    output word_t    retireData,
    output logic     halted,
    output logic     err
);
    logic  stall;
    logic  redirect;
    logic  freeze;
    word_t target;

    ifIdBus  ifId ();
    idExBus  idEx ();
    exMemBus exMem ();
    memWbBus memWb ();

    fetchStage #(.imemWords(imemWords)) fetch0 (
        .clk(clk), .rstN(rstN),
        .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
        .stall(stall), .redirect(redirect), .target(target), .freeze(freeze),
        .ifId(ifId)
    );

    decodeStage decode0 (
        .clk(clk), .rstN(rstN),
        .ifId(ifId), .idEx(idEx), .exMemMon(exMem), .memWb(memWb),
        .redirect(redirect), .stall(stall)
    );

    executeStage execute0 (
        .clk(clk), .rstN(rstN),
        .idEx(idEx), .exMem(exMem),
        .redirect(redirect), .target(target), .freeze(freeze)
    );

    memoryStage #(.dmemWords(dmemWords)) memory0 (
        .clk(clk), .rstN(rstN),
        .exMem(exMem), .memWb(memWb),
        .retireValid(retireValid), .retirePc(retirePc), .retireRegWr(retireRegWr),
        .retireReg(retireReg), .retireData(retireData),
        .halted(halted), .err(err)
    );

endmodule

/* bench/procChecker.sv */
/*
 * procChecker
 * Concurrent assertions on the status and retire outputs of procTop.
 */
`timescale 1ns/1ps

module procChecker (
    input logic clk,
    input logic rstN,
    input logic retireValid,
    input logic retireRegWr,
    input logic halted,
    input logic err
);
    haltedSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
        else $error("halted dropped while out of reset");

    errSticky: assert property (@(posedge clk) disable iff (!rstN) err |=> err)
        else $error("err dropped while out of reset");

    errHalts: assert property (@(posedge clk) disable iff (!rstN) err |-> halted)
        else $error("err high without halted");

    // The HALT itself retires in the cycle halted rises, nothing after it
    quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> !retireValid)
        else $error("retirement after halt");

    regWrNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        retireRegWr |-> retireValid)
        else $error("retireRegWr without retireValid");

endmodule

bind procTop procChecker checker0 (
    .clk(clk), .rstN(rstN),
    .retireValid(retireValid), .retireRegWr(retireRegWr),
    .halted(halted), .err(err)
);

/* bench/procTb.sv */
/*
 * procTb
 * Testbench for procTop. Random programs from an LFSR are loaded under reset,
 * run to halt, and every retirement is compared with a sequential ISA model.
 */
`timescale 1ns/1ps

module procTb import cpuPkg::*; ();
    localparam int IMEM = 256;
    localparam int DMEM = 64;

    typedef struct packed {
        word_t    pc;
        logic     wr;
        regAddr_t rd;
        word_t    data;
        logic     chk;
    } retire_t;

    logic     clk;
    logic     rstN;
    logic     progWrEn;
    word_t    progAddr;
    word_t    progData;
    logic     retireValid;
    word_t    retirePc;
    logic     retireRegWr;
    regAddr_t retireReg;
    word_t    retireData;
    logic     halted;
    logic     err;

    word_t       prog [256];
    int          progLen;
    word_t       mem [64];
    logic        memKnown [64];
    logic        genKnown [64];
    retire_t     expQ [$];
    logic        expErr;
    logic [31:0] lfsr;
    int          errors;
    int          testNum;
    int          failedTests;
    int          testErrStart;
    int          cycles;
    int          cycleLimit;

    procTop #(.imemWords(IMEM), .dmemWords(DMEM)) uut (
        .clk(clk), .rstN(rstN),
        .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
        .retireValid(retireValid), .retirePc(retirePc), .retireRegWr(retireRegWr),
        .retireReg(retireReg), .retireData(retireData),
        .halted(halted), .err(err)
    );

    always #20 clk = ~clk;

    // Counts run cycles against a limit that grows with each program
    always @(posedge clk) begin
        if (rstN) begin
            cycles++;
            if (cycles >= cycleLimit) begin
                $display("Timeout: processor did not halt within %0d cycles", cycleLimit);
                $display("*** TEST FAILED ***");
                $finish;
            end
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic nextBit();
        logic b;
        b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], b};
        return b;
    endfunction

    function automatic int unsigned randBits(int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    function automatic regAddr_t randReg();
        return regAddr_t'(randBits(3));
    endfunction

    // Instruction encoders
    function automatic word_t encR(aluOp_t f, regAddr_t rd, regAddr_t rs, regAddr_t rt);
        return {OP_ALU, rs, rt, rd, f};
    endfunction

    function automatic word_t encI(opcode_t op, regAddr_t rt, regAddr_t rs, logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encB(regAddr_t rs, logic [7:0] off);
        return {OP_BEQZ, rs, off};
    endfunction

    function automatic word_t encJ(logic [10:0] off);
        return {OP_J, off};
    endfunction

    task automatic emit(input word_t w);
        prog[8'(progLen)] = w;
        progLen++;
    endtask

    task automatic newProgram();
        progLen = 0;
        for (int i = 0; i < 64; i++) begin
            genKnown[i] = memKnown[i];
        end
    endtask

    task automatic aluInstr(input regAddr_t src, output regAddr_t dst);
        regAddr_t d;
        d = randReg();
        if (randBits(2) == 0) begin
            emit(encI(OP_ADDI, d, src, 5'(randBits(5))));
        end else begin
            emit(encR(aluOp_t'(randBits(2)), d, src, randReg()));
        end
        dst = d;
    endtask

    // Base register cleared and set so the address stays in 0..30
    task automatic memGroup();
        regAddr_t  rb;
        logic [5:0] addr;
        logic [5:0] base;
        logic       doLoad;
        rb = randReg();
        addr = 6'(randBits(5) % 31);
        doLoad = 1'b0;
        if (nextBit()) begin
            for (int t = 0; t < 8 && !doLoad; t++) begin
                addr = 6'(randBits(5) % 31);
                doLoad = genKnown[addr];
            end
        end
        base = addr >> 1;
        emit(encR(ALU_XOR, rb, rb, rb));
        emit(encI(OP_ADDI, rb, rb, 5'(base)));
        if (doLoad) begin
            emit(encI(OP_LD, randReg(), rb, 5'(addr - base)));
        end else begin
            emit(encI(OP_ST, randReg(), rb, 5'(addr - base)));
            genKnown[addr] = 1'b1;
            if (nextBit()) begin
                emit(encI(OP_LD, randReg(), rb, 5'(addr - base)));
            end
        end
    endtask

    // Forward branch over k fillers to the next group
    task automatic branchGroup();
        regAddr_t rs;
        regAddr_t d;
        int       k;
        rs = randReg();
        k = 1 + int'(randBits(2) % 3);
        case (randBits(2))
            0: emit(encJ(11'(k)));
            1: begin
                emit(encR(ALU_XOR, rs, rs, rs));
                emit(encB(rs, 8'(k)));
            end
            default: emit(encB(rs, 8'(k)));
        endcase
        repeat (k) aluInstr(randReg(), d);
    endtask

    task automatic mixGroup(inout regAddr_t last);
        case (randBits(2))
            0: aluInstr(last, last);
            1: memGroup();
            2: branchGroup();
            default: emit({OP_NOP, 11'd0});
        endcase
    endtask

    // Sequential ISA model that fills expQ and updates the data memory image
    task automatic runModel();
        word_t   regs [8];
        word_t   pc;
        word_t   w;
        word_t   a;
        word_t   v;
        word_t   rsV;
        word_t   rtV;
        retire_t e;
        logic    done;
        int      steps;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        expQ.delete();
        expErr = 1'b0;
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            w = (int'(pc) < progLen) ? prog[pc[7:0]] : {OP_NOP, 11'd0};
            e = '{pc: pc, wr: 1'b0, rd: '0, data: '0, chk: 1'b0};
            rsV = regs[w[10:8]];
            rtV = regs[w[7:5]];
            a = rsV + {{11{w[4]}}, w[4:0]};
            pc = pc + 16'd1;
            case (opcode_t'(w[15:11]))
                OP_ALU: begin
                    case (w[1:0])
                        2'b00: v = rsV + rtV;
                        2'b01: v = rsV - rtV;
                        2'b10: v = rsV & rtV;
                        default: v = rsV ^ rtV;
                    endcase
                    regs[w[4:2]] = v;
                    e = '{pc: e.pc, wr: 1'b1, rd: w[4:2], data: v, chk: 1'b1};
                end
                OP_ADDI: begin
                    regs[w[7:5]] = a;
                    e = '{pc: e.pc, wr: 1'b1, rd: w[7:5], data: a, chk: 1'b1};
                end
                OP_LD: begin
                    if (a >= 16'(DMEM)) begin
                        expErr = 1'b1;
                        done = 1'b1;
                    end else begin
                        v = mem[a[5:0]];
                        regs[w[7:5]] = v;
                        e = '{pc: e.pc, wr: 1'b1, rd: w[7:5], data: v, chk: 1'b1};
                    end
                end
                OP_ST: begin
                    if (a >= 16'(DMEM)) begin
                        expErr = 1'b1;
                        done = 1'b1;
                    end else begin
                        mem[a[5:0]] = rtV;
                        memKnown[a[5:0]] = 1'b1;
                        e.data = rtV;
                        e.chk = 1'b1;
                    end
                end
                OP_BEQZ: begin
                    if (rsV == '0) begin
                        pc = pc + {{8{w[7]}}, w[7:0]};
                    end
                end
                OP_J: pc = pc + {{5{w[10]}}, w[10:0]};
                OP_HALT: done = 1'b1;
                OP_NOP: ;
                default: begin
                    expErr = 1'b1;
                    done = 1'b1;
                end
            endcase
            expQ.push_back(e);
            steps++;
        end
    endtask

    task automatic reportMismatch(input string field, input word_t got, input word_t exp);
        $display("FAIL at %0t: %s got %h expected %h", $time, field, got, exp);
        errors++;
    endtask

    always @(negedge clk) begin : checkRetire
        retire_t e;
        if (rstN && retireValid) begin
            if (expQ.size() == 0) begin
                $display("Unexpected retirement of pc %h at %0t", retirePc, $time);
                errors++;
            end else begin
                e = expQ.pop_front();
                if (retirePc !== e.pc) begin
                    reportMismatch("retirePc", retirePc, e.pc);
                end
                if (retireRegWr !== e.wr) begin
                    reportMismatch("retireRegWr", 16'(retireRegWr), 16'(e.wr));
                end
                if (e.wr && retireReg !== e.rd) begin
                    reportMismatch("retireReg", 16'(retireReg), 16'(e.rd));
                end
                if (e.chk && retireData !== e.data) begin
                    reportMismatch("retireData", retireData, e.data);
                end
                // halted rises with the last expected retirement
                if (halted !== (expQ.size() == 0)) begin
                    reportMismatch("halted", 16'(halted), 16'(expQ.size() == 0));
                end
            end
        end
    end

    // Load under reset, release, run to halt and check the leftovers
    task automatic runProgram();
        emit({OP_HALT, 11'd0});
        runModel();
        cycleLimit = cycleLimit + 8 * progLen;
        rstN = 1'b0;
        for (int i = 0; i < progLen + 4; i++) begin
            progWrEn = 1'b1;
            progAddr = word_t'(i);
            progData = (i < progLen) ? prog[8'(i)] : {OP_NOP, 11'd0};
            @(posedge clk);
            #2;
        end
        progWrEn = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #2;
        end
        rstN = 1'b1;
        while (!halted) begin
            @(posedge clk);
            #2;
        end
        repeat (3) begin
            @(posedge clk);
            #2;
        end
        if (expQ.size() != 0) begin
            $display("Missing %0d expected retirements at %0t", expQ.size(), $time);
            errors++;
        end
        if (err !== expErr) begin
            reportMismatch("err", 16'(err), 16'(expErr));
        end
    endtask

    task automatic startTest();
        testNum++;
        testErrStart = errors;
        newProgram();
    endtask

    task automatic endTest(input string name);
        if (errors == testErrStart) begin
            $display("test %0d %s: ok", testNum, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", testNum, name,
                     errors - testErrStart);
            failedTests++;
        end
    endtask

    initial begin : mainSequence
        regAddr_t   last;
        logic [3:0] a;
        clk = 1'b0;
        rstN = 1'b0;
        progWrEn = 1'b0;
        progAddr = '0;
        progData = '0;
        lfsr = 32'h1bf4;
        errors = 0;
        testNum = 0;
        failedTests = 0;
        cycles = 0;
        cycleLimit = 50;
        for (int i = 0; i < 64; i++) begin
            memKnown[i] = 1'b0;
            mem[i] = '0;
        end
        @(posedge clk);
        #2;

        startTest();
        last = randReg();
        repeat (20) aluInstr(last, last);
        runProgram();
        endTest("dependent ALU chain");

        startTest();
        repeat (10) memGroup();
        runProgram();
        endTest("loads and stores");

        startTest();
        repeat (8) begin
            branchGroup();
            aluInstr(randReg(), last);
        end
        runProgram();
        endTest("branches and jumps");

        startTest();
        repeat (30) mixGroup(last);
        runProgram();
        endTest("random mix");

        // Only ALU work follows the fault so no store is assumed done
        startTest();
        repeat (6) mixGroup(last);
        emit({5'b11111, 11'(randBits(11))});
        repeat (4) aluInstr(last, last);
        runProgram();
        endTest("illegal opcode");

        startTest();
        emit(encR(ALU_XOR, 3'd1, 3'd1, 3'd1));
        emit(encI(OP_ADDI, 3'd1, 3'd1, 5'h1f));
        emit(encI(OP_LD, 3'd2, 3'd1, 5'd0));
        runProgram();
        a = 4'(randBits(4));
        newProgram();
        emit(encR(ALU_XOR, 3'd1, 3'd1, 3'd1));
        emit(encI(OP_ADDI, 3'd1, 3'd1, {1'b0, a}));
        emit(encI(OP_ADDI, 3'd2, 3'd1, 5'd5));
        emit(encI(OP_ST, 3'd2, 3'd1, 5'd0));
        emit(encR(ALU_XOR, 3'd3, 3'd3, 3'd3));
        repeat (4) emit(encI(OP_ADDI, 3'd3, 3'd3, 5'd15));
        emit(encI(OP_ADDI, 3'd3, 3'd3, 5'd4));
        emit(encI(OP_ADDI, 3'd4, 3'd4, 5'h1d));
        // Address 64 plus a aliases a in the low bits
        emit(encI(OP_ST, 3'd4, 3'd3, {1'b0, a}));
        runProgram();
        newProgram();
        emit(encR(ALU_XOR, 3'd5, 3'd5, 3'd5));
        emit(encI(OP_ADDI, 3'd5, 3'd5, {1'b0, a}));
        emit(encI(OP_LD, 3'd6, 3'd5, 5'd0));
        runProgram();
        endTest("data address range");

        $display("Tests run %0d, tests failed %0d, errors %0d", testNum, failedTests, errors);
        if (errors == 0 && failedTests == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* pipeCpu.f */
logic/cpuPkg.sv
logic/pipeBus.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/procTop.sv
bench/procChecker.sv
bench/procTb.sv

/* Makefile */
TOP = procTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f pipeCpu.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f pipeCpu.f -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -qF "*** TEST PASSED ***" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
